/* Makefile */
SIM = obj_dir/Vipod_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module ipod_tb -Mdir obj_dir -f list.f

run: compile
	./$(SIM) | tee sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
	  echo "Run did not complete cleanly, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* include/ipod_macros.svh */
`ifndef IPOD_MACROS_SVH
`define IPOD_MACROS_SVH

// ========================================
// Sample period, in CLK_50M cycles
// ========================================

// About 44 kHz at 50 MHz
`define SAMPLE_COUNT_DEFAULT 16'd1136

// One speed key press
`define SAMPLE_COUNT_STEP    16'd128

`define SAMPLE_COUNT_MIN     16'd624   // Fastest rate
`define SAMPLE_COUNT_MAX     16'd1648  // Slowest rate

// ========================================
// Flash layout
// ========================================

`define FLASH_LAST_ADDR      23'h7FFFF // Last audio word

`endif

/* list.f */
+incdir+include
src/flash_pkg.sv
src/player_pkg.sv
src/rate_divider.sv
src/flash_reader.sv
src/key_command.sv
src/playback_ctrl.sv
src/ipod_top.sv
test/flash_model.sv
test/ipod_tb.sv

/* src/flash_pkg.sv */
package flash_pkg;

  // ========================================
  // Flash read bus
  // ========================================

  // Word address on the flash bus
  // The audio region ends at FLASH_LAST_ADDR
  typedef logic [22:0] flash_addr_t;

  // One read word
  // Two samples packed, low half first in time when playing forward
  typedef logic [31:0] flash_word_t;

  // Reads are always full words
  // so the bus carries no byte enables

endpackage

/* src/flash_reader.sv */
module flash_reader (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    fetch_start,
  input  flash_pkg::flash_addr_t  fetch_addr,
  output flash_pkg::flash_word_t  fetch_word,
  output logic                    word_valid,
  output logic                    flash_read,
  output flash_pkg::flash_addr_t  flash_addr,
  input  logic                    flash_waitrequest,
  input  flash_pkg::flash_word_t  flash_readdata,
  input  logic                    flash_readdatavalid
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,   // Request held on the bus
    RD_DATA   // Accepted, data still to come
  } rd_state_t;

  rd_state_t state;

  // ========================================
  // Read sequencer
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= RD_IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        RD_IDLE:
          if (fetch_start)
            state <= RD_REQ;
        RD_REQ:
          if (!flash_waitrequest)
            state <= RD_DATA; // Accepted this cycle
        RD_DATA:
          if (flash_readdatavalid)
          begin
            state      <= RD_IDLE;
            word_valid <= 1'b1;
          end
        default:
          state <= RD_IDLE;
      endcase
    end
  end

  assign flash_read = (state == RD_REQ);

  // Address and data registers
  always_ff @(posedge CLK_50M)
  begin
    if (fetch_start && state == RD_IDLE)
      flash_addr <= fetch_addr;
    if (state == RD_DATA && flash_readdatavalid)
      fetch_word <= flash_readdata;
  end

  addr_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> $stable(flash_addr));

  // Controller must not overlap reads
  no_overlap: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    fetch_start |-> state == RD_IDLE);

endmodule

/* src/ipod_top.sv */
module ipod_top (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  player_pkg::ascii_t      key_ascii,
  input  logic                    key_ready,
  input  logic                    lock,
  input  logic                    speed_up,
  input  logic                    speed_down,
  input  logic                    speed_reset,
  output logic                    flash_read,
  output flash_pkg::flash_addr_t  flash_addr,
  input  logic                    flash_waitrequest,
  input  flash_pkg::flash_word_t  flash_readdata,
  input  logic                    flash_readdatavalid,
  output player_pkg::sample_t     audio_sample,
  output logic                    sample_valid,
  output player_pkg::period_t     sample_period
);

  import flash_pkg::*;

  logic        play;
  logic        dir_back;
  logic        restart;
  logic        sample_tick;
  logic        fetch_start;
  flash_addr_t fetch_addr;
  flash_word_t fetch_word;
  logic        word_valid;

  // ========================================
  // Commands and rate
  // ========================================

  key_command key_command_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key_ascii (key_ascii),
    .key_ready (key_ready),
    .lock      (lock),
    .play      (play),
    .dir_back  (dir_back),
    .restart   (restart)
  );

  rate_divider rate_divider_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .sample_tick   (sample_tick),
    .sample_period (sample_period)
  );

  // ========================================
  // Flash path and playback
  // ========================================

  flash_reader flash_reader_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .fetch_start         (fetch_start),
    .fetch_addr          (fetch_addr),
    .fetch_word          (fetch_word),
    .word_valid          (word_valid),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  playback_ctrl playback_ctrl_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .play         (play),
    .dir_back     (dir_back),
    .restart      (restart),
    .sample_tick  (sample_tick),
    .fetch_word   (fetch_word),
    .word_valid   (word_valid),
    .fetch_start  (fetch_start),
    .fetch_addr   (fetch_addr),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid)
  );

endmodule

/* src/key_command.sv */
module key_command (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  player_pkg::ascii_t key_ascii,
  input  logic              key_ready,
  input  logic              lock,
  output logic              play,
  output logic              dir_back,
  output logic              restart
);

  // ========================================
  // Command decode
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play     <= 1'b0;
      dir_back <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      restart <= 1'b0; // Pulse only
      if (key_ready && !lock)
      begin
        case (key_ascii)
          8'h45, 8'h65: play     <= 1'b1; // E e
          8'h44, 8'h64: play     <= 1'b0; // D d
          8'h46, 8'h66: dir_back <= 1'b0; // F f
          8'h42, 8'h62: dir_back <= 1'b1; // B b
          8'h52, 8'h72: restart  <= 1'b1; // R r
          default: ;
        endcase
      end
    end
  end

  // Back to back ready pulses would still need two cycles here
  restart_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    restart |=> !restart);

endmodule

/* src/playback_ctrl.sv */
`include "ipod_macros.svh"

module playback_ctrl (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    play,
  input  logic                    dir_back,
  input  logic                    restart,
  input  logic                    sample_tick,
  input  flash_pkg::flash_word_t  fetch_word,
  input  logic                    word_valid,
  output logic                    fetch_start,
  output flash_pkg::flash_addr_t  fetch_addr,
  output player_pkg::sample_t     audio_sample,
  output logic                    sample_valid
);

  import flash_pkg::*;
  import player_pkg::*;

  play_state_t state;
  flash_addr_t word_addr;  // Next address to fetch
  flash_addr_t addr_inc;
  flash_addr_t addr_dec;
  flash_word_t hold_word;
  logic        word_back;  // Direction the held word was fetched in

  // ========================================
  // Address stepping
  // ========================================

  assign addr_inc = (word_addr == `FLASH_LAST_ADDR) ? '0 : word_addr + 23'd1;
  assign addr_dec = (word_addr == '0) ? `FLASH_LAST_ADDR : word_addr - 23'd1;

  assign fetch_start = (state == FETCH);
  assign fetch_addr  = word_addr; // Sampled by the reader on fetch_start

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word_addr <= '0;
      word_back <= 1'b0;
    end
    else
    begin
      if (restart)
        word_addr <= dir_back ? `FLASH_LAST_ADDR : '0; // Used by the next fetch
      else if (state == FETCH)
        word_addr <= dir_back ? addr_dec : addr_inc;
      if (state == FETCH)
        word_back <= dir_back;
    end
  end

  // ========================================
  // Sequencer
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= IDLE;
      audio_sample <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        IDLE:
          if (sample_tick && play)
            state <= FETCH;
        FETCH:
          state <= WAIT_WORD;
        WAIT_WORD:
        begin
          // Ticks are dropped while the read is out
          if (word_valid)
          begin
            audio_sample <= word_back ? fetch_word[31:16] : fetch_word[15:0];
            sample_valid <= 1'b1;
            state        <= OUT_SECOND;
          end
        end
        OUT_SECOND:
        begin
          // Paused here keeps the second half for later
          if (sample_tick && play)
          begin
            audio_sample <= word_back ? hold_word[15:0] : hold_word[31:16];
            sample_valid <= 1'b1;
            state        <= IDLE;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == WAIT_WORD && word_valid)
      hold_word <= fetch_word;
  end

  // Reader answers only the fetch this FSM is waiting on
  word_expected: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    word_valid |-> state == WAIT_WORD);

endmodule

/* src/player_pkg.sv */
package player_pkg;

  // ========================================
  // Playback data
  // ========================================

  typedef logic signed [15:0] sample_t;  // Signed PCM sample
  typedef logic [15:0] period_t;         // Clock cycles per sample

  // ========================================
  // Commands
  // ========================================

  typedef logic [7:0] ascii_t;           // Keyboard character code

  // ========================================
  // Control FSM
  // ========================================

  typedef enum logic [1:0] {
    IDLE,       // Waiting for a tick to start a fetch
    FETCH,      // Read request handed to the reader
    WAIT_WORD,  // Word on its way back from flash
    OUT_SECOND  // First half played, second half pending
  } play_state_t;

endpackage

/* src/rate_divider.sv */
`include "ipod_macros.svh"

module rate_divider (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              speed_up,
  input  logic              speed_down,
  input  logic              speed_reset,
  output logic              sample_tick,
  output player_pkg::period_t sample_period
);

  import player_pkg::*;

  // Bit 0 up, bit 1 down, bit 2 reset
  logic [2:0] sync_1;
  logic [2:0] sync_2;
  logic [2:0] sync_prev;
  logic [2:0] rise;
  period_t    cnt;

  // ========================================
  // Key synchronizers
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_1    <= 3'b000;
      sync_2    <= 3'b000;
      sync_prev <= 3'b000;
    end
    else
    begin
      sync_1    <= {speed_reset, speed_down, speed_up};
      sync_2    <= sync_1;
      sync_prev <= sync_2;
    end
  end

  assign rise = sync_2 & ~sync_prev; // One cycle per press

  // ========================================
  // Period register
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      sample_period <= `SAMPLE_COUNT_DEFAULT;
    else if (rise[2])
      sample_period <= `SAMPLE_COUNT_DEFAULT; // Reset wins
    else if (rise[0])
      sample_period <= (sample_period >= `SAMPLE_COUNT_MIN + `SAMPLE_COUNT_STEP) ?
                       sample_period - `SAMPLE_COUNT_STEP : `SAMPLE_COUNT_MIN;
    else if (rise[1])
      sample_period <= (sample_period <= `SAMPLE_COUNT_MAX - `SAMPLE_COUNT_STEP) ?
                       sample_period + `SAMPLE_COUNT_STEP : `SAMPLE_COUNT_MAX;
  end

  // Tick counter, restarted together with any period change
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt         <= '0;
      sample_tick <= 1'b0;
    end
    else if (|rise)
    begin
      cnt         <= '0;
      sample_tick <= 1'b0;
    end
    else if (cnt == sample_period - 16'd1)
    begin
      cnt         <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      cnt         <= cnt + 16'd1;
      sample_tick <= 1'b0;
    end
  end

  period_in_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_period >= `SAMPLE_COUNT_MIN && sample_period <= `SAMPLE_COUNT_MAX);

endmodule

/* test/flash_model.sv */
module flash_model (
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  logic                   flash_read,
  input  flash_pkg::flash_addr_t flash_addr,
  output logic                   flash_waitrequest,
  output flash_pkg::flash_word_t flash_readdata,
  output logic                   flash_readdatavalid
);

  timeunit 1ns;
  timeprecision 100ps;

  import flash_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_STALL,    // Holding waitrequest high
    M_ACCEPT,   // Request taken on the last rising edge
    M_LATENCY   // Counting down to data valid
  } model_state_t;

  model_state_t state;
  logic [15:0]  lfsr;
  flash_addr_t  addr_hold;
  int           count;

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++)
    begin
      val  = (val << 1) | int'(lfsr[0]); // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Low half is the address, high half its complement
  function automatic flash_word_t word_for(flash_addr_t a);
    return {~a[15:0], a[15:0]};
  endfunction

  // ========================================
  // Bus responder, driven on falling edges
  // ========================================

  initial
  begin
    lfsr                = 16'd34;
    state               = M_IDLE;
    addr_hold           = '0;
    count               = 0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    forever
    begin
      @(negedge CLK_50M);
      flash_readdatavalid = 1'b0;
      if (!rst_n)
      begin
        state             = M_IDLE;
        flash_waitrequest = 1'b1;
      end
      else
      begin
        case (state)
          M_IDLE:
            if (flash_read)
            begin
              addr_hold = flash_addr;
              draw_bits(2, count); // 0 to 3 wait states
              if (count == 0)
              begin
                flash_waitrequest = 1'b0;
                state             = M_ACCEPT;
              end
              else
                state = M_STALL;
            end
          M_STALL:
          begin
            count = count - 1;
            if (count == 0)
            begin
              flash_waitrequest = 1'b0;
              state             = M_ACCEPT;
            end
          end
          M_ACCEPT:
          begin
            flash_waitrequest = 1'b1;
            draw_bits(2, count);
            count = count + 1;     // 1 to 4 cycles of latency
            state = M_LATENCY;
          end
          M_LATENCY:
            if (count == 1)
            begin
              flash_readdata      = word_for(addr_hold);
              flash_readdatavalid = 1'b1;
              state               = M_IDLE;
            end
            else
              count = count - 1;
        endcase
      end
    end
  end

endmodule

/* test/ipod_tb.sv */
`include "ipod_macros.svh"

module ipod_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import flash_pkg::*;
  import player_pkg::*;

  typedef enum int {ACT_KEY, ACT_LOCK, ACT_SPEED, ACT_PERIOD, ACT_SAMPLES, ACT_QUIET} action_t;

  localparam int DEF_I  = int'(`SAMPLE_COUNT_DEFAULT);
  localparam int STEP_I = int'(`SAMPLE_COUNT_STEP);
  localparam int MIN_I  = int'(`SAMPLE_COUNT_MIN);
  localparam int MAX_I  = int'(`SAMPLE_COUNT_MAX);
  localparam int KEY_E  = 'h45;
  localparam int KEY_D  = 'h44;
  localparam int KEY_F  = 'h46;
  localparam int KEY_B  = 'h42;
  localparam int KEY_R  = 'h52;

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  ascii_t      key_ascii;
  logic        key_ready;
  logic        lock;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_addr;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_valid;
  period_t     sample_period;

  // Stimulus table, one entry per row in each queue
  string   row_name[$];
  action_t row_act[$];
  int      row_arg[$];   // Key code, lock level, speed key or allowed samples
  int      row_cnt[$];   // Samples or periods
  int      row_exp[$];   // Expected period
  sample_t got_q[$];     // Samples captured by the monitor
  flash_addr_t addr_q[$];  // Word addresses accepted on the flash bus

  // Reference playback position
  flash_addr_t exp_addr;
  logic        exp_back;
  logic        half_left;   // Second half of exp_word still to play
  logic        cur_back;
  flash_word_t exp_word;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top dut_i (.*);
  flash_model flash_i (.*);

  always @(posedge CLK_50M)
  begin
    if (rst_n && sample_valid)
      got_q.push_back(audio_sample);
    if (rst_n && flash_read && !flash_waitrequest)
      addr_q.push_back(flash_addr); // Read accepted this cycle
  end

  // ========================================
  // Reference model and checks
  // ========================================

  function automatic sample_t next_expected();
    sample_t s;
    if (half_left)
    begin
      s         = cur_back ? exp_word[15:0] : exp_word[31:16];
      half_left = 1'b0;
    end
    else
    begin
      exp_word  = {~exp_addr[15:0], exp_addr[15:0]};
      cur_back  = exp_back;
      s         = exp_back ? exp_word[31:16] : exp_word[15:0];
      half_left = 1'b1;
      if (exp_back)
        exp_addr = (exp_addr == '0) ? `FLASH_LAST_ADDR : exp_addr - 23'd1;
      else
        exp_addr = (exp_addr == `FLASH_LAST_ADDR) ? '0 : exp_addr + 23'd1;
    end
    return s;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_sample(string name, sample_t exp, sample_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_period(string name, period_t exp, period_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, flash_addr_t exp, flash_addr_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected address %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_silence(string name, int allowed, int seen);
    if (seen > allowed)
    begin
      $display("CHECK FAILED %s: expected at most %0d samples, actual %0d", name, allowed, seen);
      abort_run();
    end
  endtask

  // First half of a word also checks the flash address it was read from
  task automatic expect_sample(string name, sample_t act);
    if (!half_left)
    begin
      if (addr_q.size() == 0)
      begin
        $display("Error in %s: a sample arrived without a flash read", name);
        abort_run();
      end
      check_addr(name, exp_addr, addr_q.pop_front());
    end
    check_sample(name, next_expected(), act);
  endtask

  task automatic await_sample(string name, output sample_t s);
    int n;
    n = 0;
    while (got_q.size() == 0)
    begin
      @(negedge CLK_50M);
      n++;
      if (n > 3 * MAX_I)
      begin
        $display("Timeout in %s: no sample arrived within %0d cycles", name, n);
        abort_run();
      end
    end
    s = got_q.pop_front();
  endtask

  task automatic watch_quiet(string name, int periods, int allowed);
    int      seen;
    sample_t s;
    seen = 0;
    for (int c = 0; c < periods * DEF_I; c++)
    begin
      @(negedge CLK_50M);
      while (got_q.size() > 0)
      begin
        s = got_q.pop_front();
        seen++;
        check_silence(name, allowed, seen);
        expect_sample(name, s); // In-flight sample keeps the order
      end
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  task automatic press_key(int code);
    key_ascii = ascii_t'(code);
    key_ready = 1'b1;
    @(negedge CLK_50M);
    key_ready = 1'b0;
    @(negedge CLK_50M);
    if (!lock)
    begin
      if (code == KEY_B)
        exp_back = 1'b1;
      else if (code == KEY_F)
        exp_back = 1'b0;
      else if (code == KEY_R)
        exp_addr = exp_back ? `FLASH_LAST_ADDR : '0;
    end
  endtask

  // Period settles 3 cycles after the edge
  task automatic press_speed(int which);
    speed_up    = (which == 0);
    speed_down  = (which == 1);
    speed_reset = (which == 2);
    repeat (4) @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (4) @(negedge CLK_50M);
  endtask

  task automatic add_row(string name, action_t act, int arg, int cnt, int exp);
    row_name.push_back(name);
    row_act.push_back(act);
    row_arg.push_back(arg);
    row_cnt.push_back(cnt);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    add_row("reset_period", ACT_PERIOD, 0, 0, DEF_I);
    add_row("reset_quiet", ACT_QUIET, 0, 3, 0);
    add_row("enable", ACT_KEY, KEY_E, 0, 0);
    add_row("forward_from_zero", ACT_SAMPLES, 0, 8, 0);
    add_row("pause", ACT_KEY, KEY_D, 0, 0);
    add_row("pause_quiet", ACT_QUIET, 1, 3, 0);
    add_row("resume", ACT_KEY, KEY_E, 0, 0);
    add_row("resume_continue", ACT_SAMPLES, 0, 4, 0);
    add_row("pause_for_back", ACT_KEY, KEY_D, 0, 0);
    add_row("pause_for_back_quiet", ACT_QUIET, 1, 3, 0);
    add_row("backward", ACT_KEY, KEY_B, 0, 0);
    add_row("restart_back", ACT_KEY, KEY_R, 0, 0);
    add_row("resume_back", ACT_KEY, KEY_E, 0, 0);
    add_row("backward_from_last", ACT_SAMPLES, 0, 6, 0);
    add_row("pause_for_fwd", ACT_KEY, KEY_D, 0, 0);
    add_row("pause_for_fwd_quiet", ACT_QUIET, 1, 3, 0);
    add_row("forward", ACT_KEY, KEY_F, 0, 0);
    add_row("restart_fwd", ACT_KEY, KEY_R, 0, 0);
    add_row("resume_fwd", ACT_KEY, KEY_E, 0, 0);
    add_row("forward_restart", ACT_SAMPLES, 0, 4, 0);
    add_row("lock_on", ACT_LOCK, 1, 0, 0);
    add_row("locked_restart", ACT_KEY, KEY_R, 0, 0);
    add_row("locked_pause", ACT_KEY, KEY_D, 0, 0);
    add_row("lock_off", ACT_LOCK, 0, 0, 0);
    add_row("locked_keys", ACT_SAMPLES, 0, 4, 0);
    add_row("stop", ACT_KEY, KEY_D, 0, 0);
    add_row("stop_quiet", ACT_QUIET, 1, 3, 0);
    add_row("faster_1", ACT_SPEED, 0, 0, DEF_I - STEP_I);
    add_row("faster_2", ACT_SPEED, 0, 0, DEF_I - 2 * STEP_I);
    add_row("faster_3", ACT_SPEED, 0, 0, DEF_I - 3 * STEP_I);
    add_row("faster_4", ACT_SPEED, 0, 0, DEF_I - 4 * STEP_I);
    add_row("faster_clamp", ACT_SPEED, 0, 0, MIN_I);
    add_row("speed_default", ACT_SPEED, 2, 0, DEF_I);
    add_row("slower_1", ACT_SPEED, 1, 0, DEF_I + STEP_I);
    add_row("slower_2", ACT_SPEED, 1, 0, DEF_I + 2 * STEP_I);
    add_row("slower_3", ACT_SPEED, 1, 0, DEF_I + 3 * STEP_I);
    add_row("slower_4", ACT_SPEED, 1, 0, DEF_I + 4 * STEP_I);
    add_row("slower_clamp", ACT_SPEED, 1, 0, MAX_I);
  endtask

  task automatic apply_row(int i);
    sample_t s;
    case (row_act[i])
      ACT_KEY:
        press_key(row_arg[i]);
      ACT_LOCK:
      begin
        lock = (row_arg[i] != 0);
        @(negedge CLK_50M);
      end
      ACT_SPEED:
      begin
        press_speed(row_arg[i]);
        check_period(row_name[i], period_t'(row_exp[i]), sample_period);
      end
      ACT_PERIOD:
        check_period(row_name[i], period_t'(row_exp[i]), sample_period);
      ACT_SAMPLES:
        repeat (row_cnt[i])
        begin
          await_sample(row_name[i], s);
          expect_sample(row_name[i], s);
        end
      ACT_QUIET:
        watch_quiet(row_name[i], row_cnt[i], row_arg[i]);
      default: ;
    endcase
  endtask

  initial
  begin
    rst_n       = 1'b0;
    key_ascii   = '0;
    key_ready   = 1'b0;
    lock        = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_addr    = '0;
    exp_back    = 1'b0;
    half_left   = 1'b0;
    cur_back    = 1'b0;
    exp_word    = '0;
    build_table();
    repeat (3) @(negedge CLK_50M);
    rst_n = 1'b1;
    for (int i = 0; i < row_name.size(); i++)
      apply_row(i);
    $display("Simulation passed");
    $finish;
  end

endmodule
